// File: Bender.yml
package:
  name: soc_bus

sources:
  - src/bus_pkg.sv
  - src/soc_map_pkg.sv
  - src/address_decoder.sv
  - src/bus_arbiter.sv
  - src/dma_engine.sv
  - src/work_ram.sv
  - src/flash_rom.sv
  - src/soc_bus_top.sv
  - target: test
    files:
      - testbench/soc_bus_assert.sv
      - testbench/tb_soc_bus.sv

// File: compile.f
src/bus_pkg.sv
src/soc_map_pkg.sv
src/address_decoder.sv
src/bus_arbiter.sv
src/dma_engine.sv
src/work_ram.sv
src/flash_rom.sv
src/soc_bus_top.sv
testbench/soc_bus_assert.sv
testbench/tb_soc_bus.sv

// File: src/address_decoder.sv
// maps a CPU byte address to a target
// output is TGT_NONE whenever mem_valid is low
`timescale 1ns/1ps
`default_nettype none

module address_decoder (
    input  logic                 mem_valid,
    input  bus_pkg::addr_t       addr,
    output soc_map_pkg::target_e target
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    logic in_ram;
    logic in_flash;
    logic in_status;
    logic in_dma;

    // offset compare wraps below the base, so one compare per range
    assign in_ram    = (addr - RAM_BASE) < addr_t'(RAM_WORDS * 4);
    assign in_flash  = (addr - FLASH_BASE) < addr_t'(FLASH_WORDS * 4);
    assign in_status = addr[15:2] == STATUS_ADDR[15:2];
    // four registers, 16 bytes
    assign in_dma    = addr[15:4] == DMA_BASE[15:4];

    always_comb begin
        target = TGT_NONE;
        if (mem_valid) begin
            if (in_ram) begin
                target = TGT_RAM;
            end else if (in_flash) begin
                target = TGT_FLASH;
            end else if (in_status) begin
                target = TGT_STATUS;
            end else if (in_dma) begin
                target = TGT_DMA;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
// shares the RAM port between CPU and DMA, DMA wins while busy
// mem_ready is a registered single-cycle pulse per request
// flash reads are not started while the DMA is busy
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mem_valid,
    input  bus_pkg::cpu_req_t    cpu_req,
    input  soc_map_pkg::target_e target,
    input  bus_pkg::dma_ram_t    dma,
    input  bus_pkg::data_t       ram_rdata,
    input  logic                 flash_ready,
    input  bus_pkg::data_t       flash_data,
    input  bus_pkg::data_t       status_data,
    input  bus_pkg::data_t       dma_reg_data,
    output bus_pkg::ram_req_t    ram,
    output logic                 flash_rd,
    output bus_pkg::word_addr_t  flash_index,
    output logic                 mem_ready,
    output bus_pkg::data_t       rdata
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    logic cpu_read;
    logic flash_read;
    logic fast_ready;
    logic ready_next;
    logic flash_req_q;
    logic flash_sel_q;

    assign cpu_read   = cpu_req.wstrb == '0;
    // flash writes take the fast path and are dropped
    assign flash_read = (target == TGT_FLASH) && cpu_read;
    assign fast_ready = mem_valid && !flash_read;

    // RAM port mux
    always_comb begin
        if (dma.busy) begin
            ram.cs    = 1'b1;
            ram.addr  = dma.addr;
            ram.wdata = dma.wdata;
            ram.wstrb = dma.wstrb;
        end else begin
            ram.cs    = target == TGT_RAM;
            ram.addr  = word_addr_t'((cpu_req.addr - RAM_BASE) >> 2);
            ram.wdata = cpu_req.wdata;
            ram.wstrb = cpu_req.wstrb;
        end
    end

    // one flash_rd pulse per request
    assign flash_rd    = flash_read && !flash_req_q && !dma.busy;
    assign flash_index = word_addr_t'((cpu_req.addr - FLASH_BASE) >> 2);

    // !mem_ready keeps a held request from pulsing twice
    assign ready_next = !dma.busy && !mem_ready
                        && (fast_ready || (flash_read && flash_ready));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ready   <= 1'b0;
            flash_req_q <= 1'b0;
            flash_sel_q <= 1'b0;
        end else begin
            mem_ready   <= ready_next;
            // registered select for the read mux, eases timing
            flash_sel_q <= flash_read;
            if (flash_rd) begin
                flash_req_q <= 1'b1;
            end else if (mem_ready) begin
                flash_req_q <= 1'b0;
            end
        end
    end

    // read data, valid together with mem_ready
    always_comb begin
        if (flash_sel_q) begin
            rdata = flash_data;
        end else begin
            case (target)
                TGT_RAM:    rdata = ram_rdata;
                TGT_STATUS: rdata = status_data;
                TGT_DMA:    rdata = dma_reg_data;
                // unmapped reads return zero
                default:    rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/bus_pkg.sv
// shared bus types for the CPU port, the RAM port and the DMA port
// byte addresses are 16 bits, RAM words are indexed with 12 bits
// a zero write strobe on any port means a read
`default_nettype none

package bus_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [11:0] word_addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // CPU request, held steady while mem_valid is high
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
    } cpu_req_t;

    // single RAM port after arbitration
    typedef struct packed {
        logic       cs;
        word_addr_t addr;
        data_t      wdata;
        strb_t      wstrb;
    } ram_req_t;

    // DMA side of the RAM port, busy takes priority over the CPU
    typedef struct packed {
        logic       busy;
        word_addr_t addr;
        data_t      wdata;
        strb_t      wstrb;
    } dma_ram_t;

endpackage

`default_nettype wire

// File: src/dma_engine.sv
// fill-only DMA, writes pattern + i to word dest + i for i in 0..len-1
// DEST and LEN are in words, the fill wraps at the top of RAM
// register writes take the whole word for any nonzero strobe
// reading START returns the busy flag in bit 0
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  soc_map_pkg::target_e target,
    input  bus_pkg::cpu_req_t    cpu_req,
    input  logic                 mem_ready,
    output bus_pkg::dma_ram_t    dma,
    output bus_pkg::data_t       reg_data,
    output logic [15:0]          fill_count
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic {
        DMA_IDLE,
        DMA_FILL
    } dma_state_e;

    dma_state_e state_q;
    word_addr_t dest_q;
    word_addr_t len_q;
    data_t      pattern_q;
    word_addr_t offset_q;
    logic       reg_wr;
    logic [3:0] reg_sel;

    assign reg_sel = cpu_req.addr[3:0];
    // mem_ready is a single pulse, so this fires once per write
    assign reg_wr  = (target == TGT_DMA) && mem_ready && (cpu_req.wstrb != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= DMA_IDLE;
            dest_q     <= '0;
            len_q      <= '0;
            pattern_q  <= '0;
            offset_q   <= '0;
            fill_count <= '0;
        end else begin
            if (reg_wr) begin
                case (reg_sel)
                    DMA_REG_DEST:    dest_q    <= word_addr_t'(cpu_req.wdata);
                    DMA_REG_LEN:     len_q     <= word_addr_t'(cpu_req.wdata);
                    DMA_REG_PATTERN: pattern_q <= cpu_req.wdata;
                    default:         ;
                endcase
            end
            case (state_q)
                DMA_IDLE: begin
                    // zero length start is ignored
                    if (reg_wr && reg_sel == DMA_REG_START && len_q != '0) begin
                        state_q  <= DMA_FILL;
                        offset_q <= '0;
                    end
                end
                DMA_FILL: begin
                    offset_q <= offset_q + 1'b1;
                    if (offset_q == len_q - 1'b1) begin
                        state_q    <= DMA_IDLE;
                        fill_count <= fill_count + 1'b1;
                    end
                end
                default: state_q <= DMA_IDLE;
            endcase
        end
    end

    assign dma.busy  = state_q == DMA_FILL;
    assign dma.addr  = dest_q + offset_q;
    assign dma.wdata = pattern_q + data_t'(offset_q);
    assign dma.wstrb = '1;

    always_comb begin
        case (reg_sel)
            DMA_REG_DEST:    reg_data = data_t'(dest_q);
            DMA_REG_LEN:     reg_data = data_t'(len_q);
            DMA_REG_PATTERN: reg_data = pattern_q;
            DMA_REG_START:   reg_data = data_t'(dma.busy);
            default:         reg_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/flash_rom.sv
// flash model with a fixed read latency
// word i reads as i * FLASH_HASH, truncated to 32 bits
// a new read starts only on a rising edge of rd
`timescale 1ns/1ps
`default_nettype none

module flash_rom (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd,
    input  bus_pkg::word_addr_t index,
    output logic                ready,
    output bus_pkg::data_t      data
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    logic                   rd_q;
    logic                   rd_start;
    logic [FLASH_CNT_W-1:0] count_q;
    data_t                  data_q;

    assign rd_start = rd && !rd_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q    <= 1'b0;
            count_q <= '0;
        end else begin
            rd_q <= rd;
            if (rd_start) begin
                count_q <= FLASH_CNT_W'(FLASH_LATENCY);
            end else if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // word is computed up front and held until the next read
    always_ff @(posedge clk) begin
        if (rd_start) begin
            data_q <= data_t'(index) * FLASH_HASH;
        end
    end

    // last count, FLASH_LATENCY cycles after rd rose
    assign ready = count_q == FLASH_CNT_W'(1);
    assign data  = data_q;

endmodule

`default_nettype wire

// File: src/soc_bus_top.sv
// memory bus core, CPU port in, RAM, flash, status and DMA behind it
// the CPU holds mem_valid and cpu_req until the mem_ready pulse
// status reads return STATUS_ID and the completed fill count
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_valid,
    input  bus_pkg::cpu_req_t cpu_req,
    output logic              mem_ready,
    output bus_pkg::data_t    rdata
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    target_e     target;
    dma_ram_t    dma;
    ram_req_t    ram;
    data_t       ram_rdata;
    data_t       flash_data;
    data_t       status_data;
    data_t       dma_reg_data;
    logic        flash_rd;
    logic        flash_ready;
    word_addr_t  flash_index;
    logic [15:0] fill_count;

    assign status_data = {STATUS_ID, fill_count};

    address_decoder u_decoder (
        .mem_valid (mem_valid),
        .addr      (cpu_req.addr),
        .target    (target)
    );

    bus_arbiter u_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_valid),
        .cpu_req      (cpu_req),
        .target       (target),
        .dma          (dma),
        .ram_rdata    (ram_rdata),
        .flash_ready  (flash_ready),
        .flash_data   (flash_data),
        .status_data  (status_data),
        .dma_reg_data (dma_reg_data),
        .ram          (ram),
        .flash_rd     (flash_rd),
        .flash_index  (flash_index),
        .mem_ready    (mem_ready),
        .rdata        (rdata)
    );

    dma_engine u_dma (
        .clk        (clk),
        .rst_n      (rst_n),
        .target     (target),
        .cpu_req    (cpu_req),
        .mem_ready  (mem_ready),
        .dma        (dma),
        .reg_data   (dma_reg_data),
        .fill_count (fill_count)
    );

    work_ram u_ram (
        .clk   (clk),
        .ram   (ram),
        .rdata (ram_rdata)
    );

    flash_rom u_flash (
        .clk   (clk),
        .rst_n (rst_n),
        .rd    (flash_rd),
        .index (flash_index),
        .ready (flash_ready),
        .data  (flash_data)
    );

endmodule

`default_nettype wire

// File: src/soc_map_pkg.sv
// memory map, target select and peripheral constants
// DMA registers are word aligned, only addr[3:0] picks the register
`default_nettype none

package soc_map_pkg;

    typedef enum logic [2:0] {
        TGT_RAM,
        TGT_FLASH,
        TGT_STATUS,
        TGT_DMA,
        TGT_NONE
    } target_e;

    localparam bus_pkg::addr_t RAM_BASE    = 16'h0000;
    localparam int             RAM_WORDS   = 4096;
    localparam bus_pkg::addr_t FLASH_BASE  = 16'h8000;
    localparam int             FLASH_WORDS = 4096;
    localparam bus_pkg::addr_t STATUS_ADDR = 16'hc000;
    localparam bus_pkg::addr_t DMA_BASE    = 16'hd000;

    // offsets from DMA_BASE
    localparam logic [3:0] DMA_REG_DEST    = 4'h0;
    localparam logic [3:0] DMA_REG_LEN     = 4'h4;
    localparam logic [3:0] DMA_REG_PATTERN = 4'h8;
    localparam logic [3:0] DMA_REG_START   = 4'hc;

    // flash model
    localparam int             FLASH_LATENCY = 3;
    localparam int             FLASH_CNT_W   = $clog2(FLASH_LATENCY + 1);
    localparam bus_pkg::data_t FLASH_HASH    = 32'h9e37_79b9;

    localparam logic [15:0] STATUS_ID = 16'h5a17;

endpackage

`default_nettype wire

// File: src/work_ram.sv
// single-port word RAM, byte-enable writes, registered read
// read during write returns the old word
// contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module work_ram (
    input  logic              clk,
    input  bus_pkg::ram_req_t ram,
    output bus_pkg::data_t    rdata
);
    import bus_pkg::*;
    import soc_map_pkg::*;

    data_t mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (ram.cs) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (ram.wstrb[i]) begin
                    mem[ram.addr][8*i +: 8] <= ram.wdata[8*i +: 8];
                end
            end
            rdata <= mem[ram.addr];
        end
    end

endmodule

`default_nettype wire

// File: testbench/soc_bus_assert.sv
// handshake and arbitration checks, bound into bus_arbiter
// all checks are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module soc_bus_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              mem_ready,
    input bus_pkg::dma_ram_t dma,
    input bus_pkg::ram_req_t ram
);
    // count of failed assertions
    int fail_count = 0;

    ready_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready)
        else begin
            fail_count = fail_count + 1;
            $error("mem_ready high on two consecutive cycles");
        end

    ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_ready && dma.busy))
        else begin
            fail_count = fail_count + 1;
            $error("mem_ready high while the DMA is busy");
        end

    // DMA owns the whole RAM port while busy
    ram_follows_dma: assert property (@(posedge clk) disable iff (!rst_n)
        dma.busy |-> (ram.cs && ram.addr == dma.addr && ram.wdata == dma.wdata
                      && ram.wstrb == dma.wstrb))
        else begin
            fail_count = fail_count + 1;
            $error("RAM port does not follow the DMA while busy");
        end

endmodule

bind bus_arbiter soc_bus_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_ready (mem_ready),
    .dma       (dma),
    .ram       (ram)
);

`default_nettype wire

// File: testbench/tb_soc_bus.sv
// random CPU traffic and DMA fills checked against a reference model
// RAM words are read back only after the model knows their value
// the first wrong result stops the run
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;
    import bus_pkg::*;
    import soc_map_pkg::*;

    localparam int N_RAM   = 200;
    localparam int N_FLASH = 40;
    localparam int N_FILLS = 6;
    localparam int MAX_LEN = 32;
    // worst access is a flash read plus the idle cycle, fills add their length
    localparam int MAX_TXN     = 2 * N_RAM + N_FLASH + (N_FILLS + 4) * (MAX_LEN + 12) + 20;
    localparam int CYCLE_LIMIT = MAX_TXN * (FLASH_LATENCY + 4) + (N_FILLS + 4) * MAX_LEN + 1000;

    logic        clk;
    logic        rst_n;
    logic        mem_valid;
    cpu_req_t    cpu_req;
    logic        mem_ready;
    data_t       rdata;

    data_t       model_mem [RAM_WORDS];
    bit          model_valid [RAM_WORDS];
    int          model_fills;
    word_addr_t  written_q [$];
    logic [31:0] rng_state;
    int          cycles = 0;

    soc_bus_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .cpu_req   (cpu_req),
        .mem_ready (mem_ready),
        .rdata     (rdata)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "cycle limit reached");
        end else if (UUT.u_arbiter.u_assert.fail_count != 0) begin
            $display("an assertion failed before %0t", $time);
            $display("CHECKS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic strb_t rand_strb();
        strb_t s;
        s = strb_t'(rand32());
        return (s == '0) ? 4'hf : s;
    endfunction

    function automatic word_addr_t pick_written();
        return written_q[rand32() % written_q.size()];
    endfunction

    // index times FLASH_HASH as a sum of shifted copies
    function automatic data_t hashed_word(input word_addr_t idx);
        data_t acc;
        acc = '0;
        for (int b = 0; b < $bits(word_addr_t); b++) begin
            if (idx[b]) begin
                acc = acc + (FLASH_HASH << b);
            end
        end
        return acc;
    endfunction

    // byte merge into the model RAM
    function automatic void model_store(input word_addr_t idx, input data_t data,
                                        input strb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
        if (!model_valid[idx]) begin
            model_valid[idx] = 1'b1;
            written_q.push_back(idx);
        end
    endfunction

    task automatic check_data(input data_t expected, input data_t actual, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "data compare failed");
        end
    endtask

    task automatic check_status(input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: status expected %h, got %h", $time, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "status compare failed");
        end
    endtask

    // one request, held until the mem_ready pulse, then one idle cycle
    task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t wstrb,
                              output data_t result);
        @(posedge clk);
        #2;
        mem_valid     = 1'b1;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.wstrb = wstrb;
        do begin
            @(negedge clk);
        end while (mem_ready !== 1'b1);
        result = rdata;
        @(posedge clk);
        #2;
        mem_valid = 1'b0;
    endtask

    task automatic ram_write(input word_addr_t idx, input data_t data, input strb_t strb);
        data_t unused;
        bus_access(RAM_BASE + addr_t'({idx, 2'b00}), data, strb, unused);
        model_store(idx, data, strb);
    endtask

    task automatic ram_read_check(input word_addr_t idx);
        data_t result;
        bus_access(RAM_BASE + addr_t'({idx, 2'b00}), '0, '0, result);
        check_data(model_mem[idx], result, "ram read");
    endtask

    task automatic flash_read_check(input word_addr_t idx);
        data_t result;
        bus_access(FLASH_BASE + addr_t'({idx, 2'b00}), '0, '0, result);
        check_data(hashed_word(idx), result, "flash read");
    endtask

    task automatic reg_read_check(input logic [3:0] offset, input data_t expected);
        data_t result;
        bus_access(DMA_BASE + addr_t'(offset), '0, '0, result);
        check_data(expected, result, "dma register");
    endtask

    task automatic zero_read_check(input addr_t addr);
        data_t result;
        bus_access(addr, '0, '0, result);
        check_data('0, result, "unmapped read");
    endtask

    task automatic status_check();
        data_t result;
        bus_access(STATUS_ADDR, '0, '0, result);
        check_status({STATUS_ID, 16'(model_fills)}, result);
    endtask

    // program and start a fill, the model takes it at once
    task automatic start_fill(input word_addr_t dest, input word_addr_t len, input data_t pattern);
        data_t unused;
        bus_access(DMA_BASE + addr_t'(DMA_REG_DEST), data_t'(dest), 4'hf, unused);
        bus_access(DMA_BASE + addr_t'(DMA_REG_LEN), data_t'(len), 4'hf, unused);
        bus_access(DMA_BASE + addr_t'(DMA_REG_PATTERN), pattern, 4'hf, unused);
        bus_access(DMA_BASE + addr_t'(DMA_REG_START), '0, 4'hf, unused);
        for (int i = 0; i < len; i++) begin
            model_store(dest + word_addr_t'(i), pattern + data_t'(i), 4'hf);
        end
        if (len != '0) begin
            model_fills++;
        end
    endtask

    initial begin
        data_t      result;
        word_addr_t idx;
        word_addr_t dest;
        word_addr_t len;
        data_t      pattern;
        int         start_cycle;

        clk         = 1'b0;
        rst_n       = 1'b0;
        mem_valid   = 1'b0;
        cpu_req     = '0;
        rng_state   = 32'h66a0_86a0;
        model_fills = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // RAM writes with byte enables, first write of a word is whole
        for (int i = 0; i < N_RAM; i++) begin
            idx = word_addr_t'(rand32() % 256);
            ram_write(idx, rand32(), model_valid[idx] ? rand_strb() : 4'hf);
        end
        for (int i = 0; i < N_RAM; i++) begin
            ram_read_check(pick_written());
        end

        for (int i = 0; i < N_FLASH; i++) begin
            flash_read_check(word_addr_t'(rand32()));
        end

        // fills with guarded neighbours on both sides
        for (int f = 0; f < N_FILLS; f++) begin
            dest    = word_addr_t'(rand32());
            len     = word_addr_t'(rand32() % MAX_LEN + 1);
            pattern = rand32();
            ram_write(dest - 1'b1, rand32(), 4'hf);
            ram_write(dest + len, rand32(), 4'hf);
            start_fill(dest, len, pattern);
            reg_read_check(DMA_REG_DEST, data_t'(dest));
            reg_read_check(DMA_REG_LEN, data_t'(len));
            reg_read_check(DMA_REG_PATTERN, pattern);
            for (int i = 0; i <= len + 1; i++) begin
                ram_read_check(dest - 1'b1 + word_addr_t'(i));
            end
        end

        status_check();
        dest    = word_addr_t'(rand32());
        pattern = rand32();
        start_fill(dest, '0, pattern);
        status_check();

        // requests issued while a fill is running
        dest    = word_addr_t'(rand32());
        pattern = rand32();
        start_fill(dest, word_addr_t'(MAX_LEN), pattern);
        start_cycle = cycles;
        ram_read_check(pick_written());
        if (cycles - start_cycle < MAX_LEN) begin
            $display("error at %0t: a RAM read finished while the DMA fill was running", $time);
            $display("CHECKS FAILED");
            $fatal(1, "request overtook the fill");
        end
        start_fill(word_addr_t'(rand32()), word_addr_t'(MAX_LEN), rand32());
        flash_read_check(word_addr_t'(rand32()));
        start_fill(word_addr_t'(rand32()), word_addr_t'(MAX_LEN), rand32());
        idx = pick_written();
        ram_write(idx, rand32(), rand_strb());
        ram_read_check(idx);
        status_check();

        // flash and unmapped writes alias a RAM word but must not touch it
        idx = pick_written();
        bus_access(FLASH_BASE + addr_t'({idx, 2'b00}), rand32(), 4'hf, result);
        bus_access(16'h4000 + addr_t'({idx, 2'b00}), rand32(), 4'hf, result);
        ram_read_check(idx);
        zero_read_check(16'h4000 + addr_t'({idx, 2'b00}));
        zero_read_check(16'he000);
        zero_read_check(STATUS_ADDR + 16'h0004);

        if (UUT.u_arbiter.u_assert.fail_count != 0) begin
            $display("%0d assertion failures were seen", UUT.u_arbiter.u_assert.fail_count);
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
